// File: sim.f
verilog/csr_pkg.sv
verilog/trap_pkg.sv
verilog/csr_access.sv
verilog/exc_prioritizer.sv
verilog/trap_ctrl.sv
verilog/csr_unit.sv
test/tb_csr_unit.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_csr_unit -f sim.f -o tb_csr_unit > build.log 2>&1 ||
  { cat build.log; echo "Build error" > sim.log; exit 1; }
./obj_dir/tb_csr_unit > sim.log 2>&1 ; cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; } ||
  grep -q "TEST PASSED" sim.log

// File: test/tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit;

  localparam int          WAIT_LIMIT = 20;
  localparam logic [31:0] TRAP_BASE  = 32'h0000_2000;  // mtvec after the move

  logic               clk;
  logic               rstn;
  trap_pkg::csr_req_t req;
  logic [31:0]        curr_pc;
  logic [31:0]        prev_pc;
  trap_pkg::exc_src_t exc;
  logic [2:0]         irq;  // {ext, timer, sw}
  logic               mret;
  logic [31:0]        rdata;
  logic               trap;
  logic [31:0]        trap_addr;
  logic [31:0]        lfsr;
  logic [31:0]        scratch_model;  // Expected mscratch contents

  csr_unit csr_unit_i (
    .clk_i       (clk),
    .rstn_i      (rstn),
    .req_i       (req),
    .curr_pc_i   (curr_pc),
    .prev_pc_i   (prev_pc),
    .exc_i       (exc),
    .sw_irq_i    (irq[0]),
    .timer_irq_i (irq[1]),
    .ext_irq_i   (irq[2]),
    .mret_i      (mret),
    .rdata_o     (rdata),
    .trap_o      (trap),
    .trap_addr_o (trap_addr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %08h expected %08h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // Inputs change 1 ns after the edge, outputs are sampled there too
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic csr_op(input logic [11:0] addr, input logic [31:0] wdata,
                        input logic [4:0] uimm, input logic we, input logic uimm_we,
                        input csr_pkg::wmode_e mode, output logic [31:0] old);
    req = '{addr: addr, wdata: wdata, uimm: uimm, we: we, uimm_we: uimm_we, wmode: mode};
    step();
    req = '0;
    old = rdata;  // Value before this cycle's write
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    csr_op(addr, wdata, 5'd0, 1'b1, 1'b0, csr_pkg::WMODE_NORMAL, unused);
  endtask

  task automatic read_check(input string name, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] r;
    csr_op(addr, 32'd0, 5'd0, 1'b0, 1'b0, csr_pkg::WMODE_NORMAL, r);
    check(name, r, exp);
  endtask

  task automatic expect_trap(input logic [31:0] addr);
    int cycles;
    cycles = 0;
    while (!trap) begin
      if (cycles == WAIT_LIMIT) begin
        $display("Timeout: trap_o did not rise within %0d cycles", WAIT_LIMIT);
        stop_run();
      end
      step();
      cycles++;
    end
    check("trap_addr_o", trap_addr, addr);
    step();
    check("trap_o after pulse", {31'b0, trap}, 32'd0);  // Single cycle
    check("trap_addr_o idle", trap_addr, 32'd0);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic reset_values();
    check("rdata_o at reset", rdata, 32'd0);
    check("trap_addr_o at reset", trap_addr, 32'd0);
    read_check("mvendorid", csr_pkg::CSR_ADDR_MVENDORID, csr_pkg::DEF_VAL_MVENDORID);
    read_check("marchid", csr_pkg::CSR_ADDR_MARCHID, csr_pkg::DEF_VAL_MARCHID);
    read_check("mimpid", csr_pkg::CSR_ADDR_MIMPID, csr_pkg::DEF_VAL_MIMPID);
    read_check("mhartid", csr_pkg::CSR_ADDR_MHARTID, csr_pkg::DEF_VAL_MHARTID);
    read_check("misa", csr_pkg::CSR_ADDR_MISA, csr_pkg::DEF_VAL_MISA);
    read_check("mtvec", csr_pkg::CSR_ADDR_MTVEC, {csr_pkg::DEF_VAL_MTVEC_BASE, 2'b00});
    read_check("mscratch", csr_pkg::CSR_ADDR_MSCRATCH, 32'd0);
    read_check("mepc", csr_pkg::CSR_ADDR_MEPC, 32'd0);
    read_check("mcause", csr_pkg::CSR_ADDR_MCAUSE, 32'd0);
    read_check("mtval", csr_pkg::CSR_ADDR_MTVAL, 32'd0);
    check("trap_o at reset", {31'b0, trap}, 32'd0);
  endtask

  task automatic scratch_modes();
    logic [31:0] model;
    logic [31:0] v;
    logic [31:0] old;
    rand_bits(32, v);
    csr_write(csr_pkg::CSR_ADDR_MSCRATCH, v);
    model = v;
    rand_bits(32, v);  // Set with register operand
    csr_op(csr_pkg::CSR_ADDR_MSCRATCH, v, 5'd0, 1'b1, 1'b0, csr_pkg::WMODE_SET, old);
    check("mscratch before reg set", old, model);
    model = model | v;
    rand_bits(5, v);   // Clear with immediate operand
    csr_op(csr_pkg::CSR_ADDR_MSCRATCH, 32'd0, v[4:0], 1'b0, 1'b1, csr_pkg::WMODE_CLEAR, old);
    check("mscratch before imm clear", old, model);
    model = model & ~{27'd0, v[4:0]};
    rand_bits(5, v);
    csr_op(csr_pkg::CSR_ADDR_MSCRATCH, 32'd0, v[4:0], 1'b0, 1'b1, csr_pkg::WMODE_SET, old);
    check("mscratch before imm set", old, model);
    model = model | {27'd0, v[4:0]};
    rand_bits(32, v);
    csr_op(csr_pkg::CSR_ADDR_MSCRATCH, v, 5'd0, 1'b1, 1'b0, csr_pkg::WMODE_CLEAR, old);
    check("mscratch before reg clear", old, model);
    scratch_model = model & ~v;
    read_check("mscratch final", csr_pkg::CSR_ADDR_MSCRATCH, scratch_model);
  endtask

  task automatic illegal_write();
    logic [31:0] old;
    curr_pc = 32'h0000_1234;
    csr_op(csr_pkg::CSR_ADDR_MVENDORID, 32'hffff_ffff, 5'd0, 1'b1, 1'b0,
           csr_pkg::WMODE_NORMAL, old);
    expect_trap({csr_pkg::DEF_VAL_MTVEC_BASE, 2'b00});
    read_check("mcause", csr_pkg::CSR_ADDR_MCAUSE, 32'd2);
    read_check("mepc", csr_pkg::CSR_ADDR_MEPC, 32'h0000_1234);
    read_check("mtval", csr_pkg::CSR_ADDR_MTVAL, 32'h0000_1234);
    read_check("mvendorid kept", csr_pkg::CSR_ADDR_MVENDORID, csr_pkg::DEF_VAL_MVENDORID);
    csr_write(csr_pkg::CSR_ADDR_MTVEC, TRAP_BASE | 32'h3);  // Mode bits dropped
    read_check("mtvec moved", csr_pkg::CSR_ADDR_MTVEC, TRAP_BASE);
    exc.dec_ecall = 1'b1;
    step();
    exc = '0;
    expect_trap(TRAP_BASE);
  endtask

  // Exception plus a same-cycle mscratch write that must be dropped
  task automatic exc_case(input trap_pkg::exc_src_t src, input logic [31:0] cause,
                          input logic [31:0] tval, input logic [31:0] epc);
    logic [31:0] v;
    logic [31:0] old;
    rand_bits(32, v);
    exc = src;
    csr_op(csr_pkg::CSR_ADDR_MSCRATCH, v, 5'd0, 1'b1, 1'b0, csr_pkg::WMODE_NORMAL, old);
    exc = '0;
    check("mscratch before blocked write", old, scratch_model);
    expect_trap(TRAP_BASE);
    read_check("mcause", csr_pkg::CSR_ADDR_MCAUSE, cause);
    read_check("mtval", csr_pkg::CSR_ADDR_MTVAL, tval);
    read_check("mepc", csr_pkg::CSR_ADDR_MEPC, epc);
    read_check("mscratch blocked", csr_pkg::CSR_ADDR_MSCRATCH, scratch_model);
  endtask

  task automatic exc_priority();
    trap_pkg::exc_src_t s;
    curr_pc = 32'h0000_4000;
    prev_pc = 32'h0000_3ffc;
    s = '{ifu_exc: 1'b1, ifu_mtval: 32'h0000_5002, lsu_load: 1'b1, lsu_store: 1'b1,
          lsu_addr: 32'h0000_6001, dec_illegal: 1'b1, dec_ecall: 1'b1, dec_ebreak: 1'b1};
    exc_case(s, 32'd2, curr_pc, curr_pc);
    s.dec_illegal = 1'b0;
    exc_case(s, 32'd0, 32'h0000_5002, prev_pc);
    s.ifu_exc = 1'b0;
    exc_case(s, 32'd11, 32'd0, curr_pc);
    s.dec_ecall = 1'b0;
    exc_case(s, 32'd3, curr_pc, curr_pc);
    s.dec_ebreak = 1'b0;
    exc_case(s, 32'd6, 32'h0000_6001, prev_pc);
    s.lsu_store = 1'b0;
    exc_case(s, 32'd4, 32'h0000_6001, prev_pc);
  endtask

  task automatic mret_return();
    logic [31:0] r;
    curr_pc = 32'h0000_0800;
    csr_write(csr_pkg::CSR_ADDR_MSTATUS, 32'h0000_0008);
    read_check("mstatus MIE on", csr_pkg::CSR_ADDR_MSTATUS, 32'h0000_0008);
    exc.dec_ebreak = 1'b1;
    step();
    exc = '0;
    expect_trap(TRAP_BASE);
    read_check("mstatus in trap", csr_pkg::CSR_ADDR_MSTATUS, 32'h0000_0080);
    mret = 1'b1;
    step();
    mret = 1'b0;
    expect_trap(32'h0000_0800);  // Back to mepc
    csr_op(csr_pkg::CSR_ADDR_MSTATUS, 32'd0, 5'd0, 1'b0, 1'b0, csr_pkg::WMODE_NORMAL, r);
    check("mstatus.MIE after mret", {31'b0, r[3]}, 32'd1);
  endtask

  task automatic irq_and_mie();
    irq = 3'b101;
    step();
    read_check("mip sw+ext", csr_pkg::CSR_ADDR_MIP, 32'h0000_0808);
    irq = 3'b010;
    step();
    read_check("mip timer", csr_pkg::CSR_ADDR_MIP, 32'h0000_0080);
    irq = 3'b000;
    csr_write(csr_pkg::CSR_ADDR_MIE, 32'hffff_ffff);
    read_check("mie enables only", csr_pkg::CSR_ADDR_MIE, 32'h0000_0888);
  endtask

  initial begin
    rstn          = 1'b0;
    req           = '0;
    curr_pc       = '0;
    prev_pc       = '0;
    exc           = '0;
    irq           = '0;
    mret          = 1'b0;
    lfsr          = 32'hf8147e30;
    scratch_model = '0;
    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b1;
    reset_values();
    scratch_modes();
    illegal_write();
    exc_priority();
    mret_return();
    irq_and_mie();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: verilog/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
  input  logic                     clk_i,
  input  logic                     rstn_i,
  input  trap_pkg::csr_req_t       req_i,
  input  logic [csr_pkg::XLEN-1:0] curr_pc_i,
  input  logic [csr_pkg::XLEN-1:0] prev_pc_i,
  input  trap_pkg::exc_src_t       exc_i,
  input  logic                     sw_irq_i,
  input  logic                     timer_irq_i,
  input  logic                     ext_irq_i,
  input  logic                     mret_i,
  output logic [csr_pkg::XLEN-1:0] rdata_o,
  output logic                     trap_o,
  output logic [csr_pkg::XLEN-1:0] trap_addr_o
);

  trap_pkg::csr_state_t     state;
  trap_pkg::csr_wr_t        wr;
  trap_pkg::trap_rec_t      rec;
  logic                     illegal;
  logic [csr_pkg::XLEN-1:0] rdata_comb;

  csr_access csr_access_i (
    .req_i     (req_i),
    .state_i   (state),
    .rdata_o   (rdata_comb),
    .wr_o      (wr),
    .illegal_o (illegal)
  );

  exc_prioritizer exc_prioritizer_i (
    .src_i     (exc_i),
    .curr_pc_i (curr_pc_i),
    .prev_pc_i (prev_pc_i),
    .rec_o     (rec)
  );

  trap_ctrl trap_ctrl_i (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .rec_i       (rec),
    .illegal_i   (illegal),
    .wr_i        (wr),
    .mret_i      (mret_i),
    .curr_pc_i   (curr_pc_i),
    .irq_i       ({ext_irq_i, timer_irq_i, sw_irq_i}),
    .state_o     (state),
    .trap_o      (trap_o),
    .trap_addr_o (trap_addr_o)
  );

  // Read data lands a cycle later, showing the pre-write value
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rdata_o <= '0;
    end else begin
      rdata_o <= rdata_comb;
    end
  end

endmodule

// File: verilog/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
  input  logic                     clk_i,
  input  logic                     rstn_i,
  input  trap_pkg::trap_rec_t      rec_i,
  input  logic                     illegal_i,
  input  trap_pkg::csr_wr_t        wr_i,
  input  logic                     mret_i,
  input  logic [csr_pkg::XLEN-1:0] curr_pc_i,
  input  logic [2:0]               irq_i,  // {ext, timer, sw}
  output trap_pkg::csr_state_t     state_o,
  output logic                     trap_o,
  output logic [csr_pkg::XLEN-1:0] trap_addr_o
);

  trap_pkg::csr_state_t state_q;
  trap_pkg::trap_rec_t  trap;

  // Illegal CSR access behaves like a decoder illegal instruction
  always_comb begin
    if (illegal_i) begin
      trap.valid = 1'b1;
      trap.cause = csr_pkg::MCAUSE_ILLEGAL_INSTR;
      trap.mtval = curr_pc_i;
      trap.epc   = curr_pc_i;
    end else begin
      trap = rec_i;
    end
  end

  //////////////////////////////////////////////////
  // CSR state
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q            <= '0;
      state_q.mtvec_base <= csr_pkg::DEF_VAL_MTVEC_BASE;
    end else begin
      state_q.mip <= irq_i;  // One cycle behind the lines
      if (trap.valid) begin
        state_q.mepc   <= trap.epc;
        state_q.mcause <= trap.cause;
        state_q.mtval  <= trap.mtval;
        state_q.mpie   <= state_q.mie;
        state_q.mie    <= 1'b0;
      end else begin
        if (wr_i.mstatus_en) begin
          state_q.mie  <= wr_i.data[csr_pkg::MSTATUS_BIT_MIE];
          state_q.mpie <= wr_i.data[csr_pkg::MSTATUS_BIT_MPIE];
        end
        if (wr_i.mtvec_en) begin
          state_q.mtvec_base <= wr_i.data[csr_pkg::XLEN-1 -: csr_pkg::MTVEC_BASE_LEN];
        end
        if (wr_i.mie_en) begin
          state_q.mie_en <= {wr_i.data[csr_pkg::MIE_BIT_MEIE],
                             wr_i.data[csr_pkg::MIE_BIT_MTIE],
                             wr_i.data[csr_pkg::MIE_BIT_MSIE]};
        end
        if (wr_i.mscratch_en) state_q.mscratch <= wr_i.data;
        if (wr_i.mepc_en)     state_q.mepc     <= wr_i.data;
        if (wr_i.mcause_en)   state_q.mcause   <= wr_i.data;
        if (wr_i.mtval_en)    state_q.mtval    <= wr_i.data;
        if (mret_i) begin
          state_q.mie <= state_q.mpie;  // Restore interrupt enable
        end
      end
    end
  end

  assign state_o = state_q;

  //////////////////////////////////////////////////
  // Redirect to fetch
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      trap_o      <= 1'b0;
      trap_addr_o <= '0;
    end else begin
      trap_o <= trap.valid | mret_i;
      if (trap.valid) begin
        trap_addr_o <= {state_q.mtvec_base, {(csr_pkg::XLEN-csr_pkg::MTVEC_BASE_LEN){1'b0}}};
      end else if (mret_i) begin
        trap_addr_o <= state_q.mepc;
      end else begin
        trap_addr_o <= '0;
      end
    end
  end

endmodule

// File: verilog/exc_prioritizer.sv
`timescale 1ns/1ps

module exc_prioritizer (
  input  trap_pkg::exc_src_t       src_i,
  input  logic [csr_pkg::XLEN-1:0] curr_pc_i,
  input  logic [csr_pkg::XLEN-1:0] prev_pc_i,
  output trap_pkg::trap_rec_t      rec_o
);

  assign rec_o.valid = src_i.dec_illegal | src_i.ifu_exc | src_i.dec_ecall |
                       src_i.dec_ebreak | src_i.lsu_store | src_i.lsu_load;

  // Decoder faults point at the current PC, fetch and LSU faults at the previous one
  always_comb begin
    if (src_i.dec_illegal) begin
      rec_o.cause = csr_pkg::MCAUSE_ILLEGAL_INSTR;
      rec_o.mtval = curr_pc_i;
      rec_o.epc   = curr_pc_i;
    end else if (src_i.ifu_exc) begin
      rec_o.cause = csr_pkg::MCAUSE_INSTR_MISALIGNED;
      rec_o.mtval = src_i.ifu_mtval;  // Faulting target from fetch
      rec_o.epc   = prev_pc_i;
    end else if (src_i.dec_ecall) begin
      rec_o.cause = csr_pkg::MCAUSE_ECALL_M;
      rec_o.mtval = '0;
      rec_o.epc   = curr_pc_i;
    end else if (src_i.dec_ebreak) begin
      rec_o.cause = csr_pkg::MCAUSE_BREAKPOINT;
      rec_o.mtval = curr_pc_i;
      rec_o.epc   = curr_pc_i;
    end else if (src_i.lsu_store) begin
      rec_o.cause = csr_pkg::MCAUSE_STORE_MISALIGNED;
      rec_o.mtval = src_i.lsu_addr;
      rec_o.epc   = prev_pc_i;
    end else if (src_i.lsu_load) begin
      rec_o.cause = csr_pkg::MCAUSE_LOAD_MISALIGNED;
      rec_o.mtval = src_i.lsu_addr;
      rec_o.epc   = prev_pc_i;
    end else begin
      // No exception
      rec_o.cause = '0;
      rec_o.mtval = '0;
      rec_o.epc   = '0;
    end
  end

endmodule

// File: verilog/csr_access.sv
`timescale 1ns/1ps

module csr_access (
  input  trap_pkg::csr_req_t       req_i,
  input  trap_pkg::csr_state_t     state_i,
  output logic [csr_pkg::XLEN-1:0] rdata_o,
  output trap_pkg::csr_wr_t        wr_o,
  output logic                     illegal_o
);

  logic [csr_pkg::XLEN-1:0] operand;
  logic [csr_pkg::XLEN-1:0] wdata_mod;
  logic                     any_we;
  trap_pkg::csr_wr_t        wr_sel;

  assign any_we  = req_i.we | req_i.uimm_we;
  assign operand = req_i.uimm_we ?
                   {{(csr_pkg::XLEN-csr_pkg::UIMM_WIDTH){1'b0}}, req_i.uimm} : req_i.wdata;

  // Set and clear act on the value read in the same cycle
  always_comb begin
    case (req_i.wmode)
      csr_pkg::WMODE_SET:   wdata_mod = rdata_o | operand;
      csr_pkg::WMODE_CLEAR: wdata_mod = rdata_o & ~operand;
      default:              wdata_mod = operand;
    endcase
  end

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////
  always_comb begin
    rdata_o   = '0;
    illegal_o = 1'b0;
    wr_sel    = '0;
    case (req_i.addr)
      csr_pkg::CSR_ADDR_MVENDORID: begin
        rdata_o   = csr_pkg::DEF_VAL_MVENDORID;
        illegal_o = any_we;  // Read-only
      end
      csr_pkg::CSR_ADDR_MARCHID: begin
        rdata_o   = csr_pkg::DEF_VAL_MARCHID;
        illegal_o = any_we;
      end
      csr_pkg::CSR_ADDR_MIMPID: begin
        rdata_o   = csr_pkg::DEF_VAL_MIMPID;
        illegal_o = any_we;
      end
      csr_pkg::CSR_ADDR_MHARTID: begin
        rdata_o   = csr_pkg::DEF_VAL_MHARTID;
        illegal_o = any_we;
      end
      csr_pkg::CSR_ADDR_MISA: begin
        rdata_o = csr_pkg::DEF_VAL_MISA;  // Writes dropped silently
      end
      csr_pkg::CSR_ADDR_MSTATUS: begin
        rdata_o[csr_pkg::MSTATUS_BIT_MIE]  = state_i.mie;
        rdata_o[csr_pkg::MSTATUS_BIT_MPIE] = state_i.mpie;
        wr_sel.mstatus_en = any_we;
      end
      csr_pkg::CSR_ADDR_MTVEC: begin
        rdata_o = {state_i.mtvec_base, {(csr_pkg::XLEN-csr_pkg::MTVEC_BASE_LEN){1'b0}}};
        wr_sel.mtvec_en = any_we;
      end
      csr_pkg::CSR_ADDR_MIE: begin
        rdata_o[csr_pkg::MIE_BIT_MSIE] = state_i.mie_en[0];
        rdata_o[csr_pkg::MIE_BIT_MTIE] = state_i.mie_en[1];
        rdata_o[csr_pkg::MIE_BIT_MEIE] = state_i.mie_en[2];
        wr_sel.mie_en = any_we;
      end
      csr_pkg::CSR_ADDR_MIP: begin
        // Pending bits follow the irq lines only
        rdata_o[csr_pkg::MIE_BIT_MSIE] = state_i.mip[0];
        rdata_o[csr_pkg::MIE_BIT_MTIE] = state_i.mip[1];
        rdata_o[csr_pkg::MIE_BIT_MEIE] = state_i.mip[2];
      end
      csr_pkg::CSR_ADDR_MSCRATCH: begin
        rdata_o            = state_i.mscratch;
        wr_sel.mscratch_en = any_we;
      end
      csr_pkg::CSR_ADDR_MEPC: begin
        rdata_o        = state_i.mepc;
        wr_sel.mepc_en = any_we;
      end
      csr_pkg::CSR_ADDR_MCAUSE: begin
        rdata_o          = state_i.mcause;
        wr_sel.mcause_en = any_we;
      end
      csr_pkg::CSR_ADDR_MTVAL: begin
        rdata_o         = state_i.mtval;
        wr_sel.mtval_en = any_we;
      end
      default: begin
        illegal_o = any_we;  // Unimplemented address
      end
    endcase
  end

  always_comb begin
    wr_o      = wr_sel;
    wr_o.data = wdata_mod;
  end

endmodule

// File: verilog/trap_pkg.sv
package trap_pkg;

  // Access request from the decoder
  typedef struct packed {
    logic [csr_pkg::CSR_ADDR_WIDTH-1:0] addr;
    logic [csr_pkg::XLEN-1:0]           wdata;
    logic [csr_pkg::UIMM_WIDTH-1:0]     uimm;
    logic                               we;       // Register operand write
    logic                               uimm_we;  // Immediate operand write
    csr_pkg::wmode_e                    wmode;
  } csr_req_t;

  // Pipeline exception sources
  typedef struct packed {
    logic                     ifu_exc;
    logic [csr_pkg::XLEN-1:0] ifu_mtval;
    logic                     lsu_load;
    logic                     lsu_store;
    logic [csr_pkg::XLEN-1:0] lsu_addr;
    logic                     dec_illegal;
    logic                     dec_ecall;
    logic                     dec_ebreak;
  } exc_src_t;

  typedef struct packed {
    logic                     valid;
    logic [csr_pkg::XLEN-1:0] cause;
    logic [csr_pkg::XLEN-1:0] mtval;
    logic [csr_pkg::XLEN-1:0] epc;
  } trap_rec_t;

  typedef struct packed {
    logic                               mie;
    logic                               mpie;
    logic [csr_pkg::MTVEC_BASE_LEN-1:0] mtvec_base;
    logic [2:0]                         mie_en;  // {meie, mtie, msie}
    logic [2:0]                         mip;     // {meip, mtip, msip}
    logic [csr_pkg::XLEN-1:0]           mscratch;
    logic [csr_pkg::XLEN-1:0]           mepc;
    logic [csr_pkg::XLEN-1:0]           mcause;
    logic [csr_pkg::XLEN-1:0]           mtval;
  } csr_state_t;

  // Field write enables plus the mode-adjusted value
  typedef struct packed {
    logic                     mstatus_en;
    logic                     mtvec_en;
    logic                     mie_en;
    logic                     mscratch_en;
    logic                     mepc_en;
    logic                     mcause_en;
    logic                     mtval_en;
    logic [csr_pkg::XLEN-1:0] data;
  } csr_wr_t;

endpackage

// File: verilog/csr_pkg.sv
package csr_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  localparam int XLEN           = 32;
  localparam int CSR_ADDR_WIDTH = 12;
  localparam int UIMM_WIDTH     = 5;   // csrrwi/csrrsi/csrrci operand
  localparam int MTVEC_BASE_LEN = 30;  // Direct mode only

  //////////////////////////////////////////////////
  // Machine-mode CSR addresses
  //////////////////////////////////////////////////
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MVENDORID = 12'hF11;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MARCHID   = 12'hF12;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MIMPID    = 12'hF13;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MHARTID   = 12'hF14;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MSTATUS   = 12'h300;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MISA      = 12'h301;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MIE       = 12'h304;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MTVEC     = 12'h305;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MSCRATCH  = 12'h340;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MEPC      = 12'h341;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MCAUSE    = 12'h342;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MTVAL     = 12'h343;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ADDR_MIP       = 12'h344;

  // Identity values
  localparam logic [XLEN-1:0] DEF_VAL_MVENDORID = 32'h0000_0000;  // Non-commercial
  localparam logic [XLEN-1:0] DEF_VAL_MARCHID   = 32'h0000_0000;
  localparam logic [XLEN-1:0] DEF_VAL_MIMPID    = 32'h0000_0001;
  localparam logic [XLEN-1:0] DEF_VAL_MHARTID   = 32'h0000_0000;  // Single hart
  localparam logic [XLEN-1:0] DEF_VAL_MISA      = 32'h4000_0100;  // RV32I

  localparam logic [MTVEC_BASE_LEN-1:0] DEF_VAL_MTVEC_BASE = 30'h0000_0040;  // 0x100

  // Field bit positions, mip shares the mie layout
  localparam int MSTATUS_BIT_MIE  = 3;
  localparam int MSTATUS_BIT_MPIE = 7;
  localparam int MIE_BIT_MSIE     = 3;
  localparam int MIE_BIT_MTIE     = 7;
  localparam int MIE_BIT_MEIE     = 11;

  typedef enum logic [1:0] {
    WMODE_NORMAL = 2'b00,
    WMODE_SET    = 2'b01,
    WMODE_CLEAR  = 2'b10
  } wmode_e;

  //////////////////////////////////////////////////
  // mcause exception codes
  //////////////////////////////////////////////////
  localparam logic [XLEN-1:0] MCAUSE_INSTR_MISALIGNED = 32'd0;
  localparam logic [XLEN-1:0] MCAUSE_ILLEGAL_INSTR    = 32'd2;
  localparam logic [XLEN-1:0] MCAUSE_BREAKPOINT       = 32'd3;
  localparam logic [XLEN-1:0] MCAUSE_LOAD_MISALIGNED  = 32'd4;
  localparam logic [XLEN-1:0] MCAUSE_STORE_MISALIGNED = 32'd6;
  localparam logic [XLEN-1:0] MCAUSE_ECALL_M          = 32'd11;

endpackage
